/* verilog/exec_pkg.sv */
package exec_pkg;

	// tag carried with every issued operation
	parameter int tag_width = 6;

	// result of an undefined alu or multiply function
	parameter logic [31:0] poison_value = 32'hfacebeec;

	// alu and multiply functions using 14 of 16 codes
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_sll    = 4'd7,
		alu_srl    = 4'd8,
		alu_sra    = 4'd9,
		alu_mul    = 4'd10,
		alu_mulh   = 4'd11,
		alu_mulhsu = 4'd12,
		alu_mulhu  = 4'd13
	} alu_func_e;

	// branch conditions in risc-v funct3 coding
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} br_func_e;

	// one function field whose view follows the unit select
	typedef union packed {
		alu_func_e alu;      // alu and mul units
		struct packed {
			logic     unused; // top bit ignored by branches
			br_func_e cond;
		} br;
	} exec_func_u;

	// target unit of an issue
	typedef enum logic [1:0] {
		unit_alu = 2'd0,
		unit_br  = 2'd1,
		unit_mul = 2'd2,
		unit_inv = 2'd3  // never starts a unit
	} fu_unit_e;

endpackage

/* verilog/alu.sv */
`timescale 1ns/100ps

// integer alu with one cycle from start to valid
module alu #(
	parameter int xlen = 32
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic [xlen-1:0]      opa,
	input  logic [xlen-1:0]      opb,
	input  exec_pkg::alu_func_e  func,
	output logic                 valid,
	output logic [xlen-1:0]      result
);

	localparam int shamt_w = $clog2(xlen);  // 5 for rv32, 6 for rv64

	logic [xlen-1:0]        next_result;
	logic [shamt_w-1:0]     shamt;
	logic signed [xlen-1:0] signed_opa;
	logic signed [xlen-1:0] signed_opb;
	logic                   lt_signed;
	logic                   lt_unsigned;

	assign shamt       = opb[shamt_w-1:0];  // low bits only
	assign signed_opa  = opa;
	assign signed_opb  = opb;
	assign lt_signed   = signed_opa < signed_opb;
	assign lt_unsigned = opa < opb;

	always_comb begin
		case (func)
			exec_pkg::alu_add:  next_result = opa + opb;
			exec_pkg::alu_sub:  next_result = opa - opb;
			exec_pkg::alu_and:  next_result = opa & opb;
			exec_pkg::alu_or:   next_result = opa | opb;
			exec_pkg::alu_xor:  next_result = opa ^ opb;
			exec_pkg::alu_slt:  next_result = {{(xlen-1){1'b0}}, lt_signed};
			exec_pkg::alu_sltu: next_result = {{(xlen-1){1'b0}}, lt_unsigned};
			exec_pkg::alu_sll:  next_result = opa << shamt;
			exec_pkg::alu_srl:  next_result = opa >> shamt;
			exec_pkg::alu_sra:  next_result = signed_opa >>> shamt;  // sign fill
			// multiply codes land here too since mlu owns them
			default:            next_result = xlen'(exec_pkg::poison_value);
		endcase
	end

	// result clears whenever no start
	always_ff @(posedge clock) begin
		if (reset || !start) begin
			valid  <= 1'b0;
			result <= '0;
		end else begin
			valid  <= 1'b1;
			result <= next_result;
		end
	end

endmodule

/* verilog/brcond.sv */
`timescale 1ns/100ps

// branch condition unit with a registered flag
module brcond #(
	parameter int xlen = 32
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  logic [xlen-1:0]     rs1,   // compared against rs2
	input  logic [xlen-1:0]     rs2,
	input  exec_pkg::br_func_e  func,
	output logic                valid,
	output logic                cond   // 1 means taken
);

	logic signed [xlen-1:0] signed_rs1;
	logic signed [xlen-1:0] signed_rs2;
	logic                   next_cond;

	assign signed_rs1 = rs1;
	assign signed_rs2 = rs2;

	always_comb begin
		case (func)
			exec_pkg::br_beq:  next_cond = rs1 == rs2;
			exec_pkg::br_bne:  next_cond = rs1 != rs2;
			exec_pkg::br_blt:  next_cond = signed_rs1 < signed_rs2;
			exec_pkg::br_bge:  next_cond = signed_rs1 >= signed_rs2;
			exec_pkg::br_bltu: next_cond = rs1 < rs2;
			exec_pkg::br_bgeu: next_cond = rs1 >= rs2;
			default:           next_cond = 1'b0;  // 010 and 011 are never taken
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset || !start) begin
			valid <= 1'b0;
			cond  <= 1'b0;
		end else begin
			valid <= 1'b1;
			cond  <= next_cond;
		end
	end

endmodule

/* verilog/mlu.sv */
`timescale 1ns/100ps

// multiplier giving the low or high word of a 2*xlen product
module mlu #(
	parameter int xlen = 32
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic [xlen-1:0]      opa,
	input  logic [xlen-1:0]      opb,
	input  exec_pkg::alu_func_e  func,
	output logic                 valid,
	output logic [xlen-1:0]      result
);

	logic [2*xlen-1:0] opa_sext;  // operands widened both ways
	logic [2*xlen-1:0] opb_sext;
	logic [2*xlen-1:0] opa_zext;
	logic [2*xlen-1:0] opb_zext;
	logic [2*xlen-1:0] prod_ss;
	logic [2*xlen-1:0] prod_su;
	logic [2*xlen-1:0] prod_uu;
	logic [xlen-1:0]   next_result;

	assign opa_sext = {{xlen{opa[xlen-1]}}, opa};
	assign opb_sext = {{xlen{opb[xlen-1]}}, opb};
	assign opa_zext = {{xlen{1'b0}}, opa};
	assign opb_zext = {{xlen{1'b0}}, opb};

	// modulo 2^(2*xlen) the extended product is exact
	assign prod_ss = opa_sext * opb_sext;
	assign prod_su = opa_sext * opb_zext;  // signed by unsigned
	assign prod_uu = opa_zext * opb_zext;

	always_comb begin
		case (func)
			exec_pkg::alu_mul:    next_result = prod_ss[xlen-1:0];  // low word is sign agnostic
			exec_pkg::alu_mulh:   next_result = prod_ss[2*xlen-1:xlen];
			exec_pkg::alu_mulhsu: next_result = prod_su[2*xlen-1:xlen];
			exec_pkg::alu_mulhu:  next_result = prod_uu[2*xlen-1:xlen];
			default:              next_result = xlen'(exec_pkg::poison_value);
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset || !start) begin
			valid  <= 1'b0;
			result <= '0;
		end else begin
			valid  <= 1'b1;
			result <= next_result;
		end
	end

endmodule

/* verilog/fu_steer.sv */
`timescale 1ns/100ps

// issue decode into unit starts, tag pipe, completion bus merge
module fu_steer #(
	parameter int xlen      = 32,
	parameter int tag_width = 6
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue_valid,
	input  exec_pkg::fu_unit_e    issue_unit,
	input  logic [tag_width-1:0]  issue_tag,
	input  logic                  refresh,      // flush drops this cycle's issue
	input  logic                  alu_valid,
	input  logic [xlen-1:0]       alu_result,
	input  logic                  br_valid,
	input  logic                  br_cond,
	input  logic                  mul_valid,
	input  logic [xlen-1:0]       mul_result,
	output logic                  alu_start,
	output logic                  br_start,
	output logic                  mul_start,
	output logic                  cdb_valid,
	output logic [tag_width-1:0]  cdb_tag,
	output logic [xlen-1:0]       cdb_value,
	output logic                  cdb_taken
);

	logic                 accept;
	logic                 any_start;
	logic [tag_width-1:0] tag_q;   // tag of the op now in a unit
	exec_pkg::fu_unit_e   unit_q;  // unit holding that op or unit_inv if none

	assign accept    = issue_valid && !refresh;
	assign alu_start = accept && (issue_unit == exec_pkg::unit_alu);
	assign br_start  = accept && (issue_unit == exec_pkg::unit_br);
	assign mul_start = accept && (issue_unit == exec_pkg::unit_mul);
	assign any_start = alu_start || br_start || mul_start;  // false for unit code 3

	always_ff @(posedge clock) begin
		if (reset) begin
			unit_q <= exec_pkg::unit_inv;
		end else begin
			unit_q <= any_start ? issue_unit : exec_pkg::unit_inv;
		end
	end

	// tag follows its op into the unit
	always_ff @(posedge clock) begin
		if (any_start) begin
			tag_q <= issue_tag;
		end
	end

	assign cdb_valid = alu_valid || br_valid || mul_valid;  // units are one-hot
	assign cdb_tag   = tag_q;

	// unit_q picks the source and that unit's valid gates it
	always_comb begin
		cdb_value = '0;
		cdb_taken = 1'b0;
		case (unit_q)
			exec_pkg::unit_alu: if (alu_valid) cdb_value = alu_result;
			exec_pkg::unit_mul: if (mul_valid) cdb_value = mul_result;
			exec_pkg::unit_br: begin
				if (br_valid) begin
					cdb_value = {{(xlen-1){1'b0}}, br_cond};  // condition as 0/1
					cdb_taken = br_cond;
				end
			end
			default: ;  // idle bus stays zero
		endcase
	end

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/100ps

// integer execute stage with steer plus alu, branch and multiply units
module exec_stage #(
	parameter int xlen      = 32,
	parameter int tag_width = exec_pkg::tag_width
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue_valid,
	input  exec_pkg::fu_unit_e    issue_unit,
	input  exec_pkg::exec_func_u  issue_func,
	input  logic [tag_width-1:0]  issue_tag,
	input  logic [xlen-1:0]       opa,
	input  logic [xlen-1:0]       opb,
	input  logic                  refresh,
	output logic                  cdb_valid,
	output logic [tag_width-1:0]  cdb_tag,
	output logic [xlen-1:0]       cdb_value,
	output logic                  cdb_taken
);

	logic            alu_start;
	logic            br_start;
	logic            mul_start;
	logic            alu_valid;
	logic [xlen-1:0] alu_result;
	logic            br_valid;
	logic            br_cond;
	logic            mul_valid;
	logic [xlen-1:0] mul_result;

	fu_steer #(.xlen(xlen), .tag_width(tag_width)) fu_steer_i (
		.clock, .reset, .issue_valid, .issue_unit, .issue_tag, .refresh,
		.alu_valid, .alu_result, .br_valid, .br_cond, .mul_valid, .mul_result,
		.alu_start, .br_start, .mul_start,
		.cdb_valid, .cdb_tag, .cdb_value, .cdb_taken
	);

	// alu and mlu read the alu view of the function field
	alu #(.xlen(xlen)) alu_i (
		.clock, .reset, .start(alu_start), .opa, .opb,
		.func(issue_func.alu), .valid(alu_valid), .result(alu_result)
	);

	brcond #(.xlen(xlen)) brcond_i (
		.clock, .reset, .start(br_start), .rs1(opa), .rs2(opb),
		.func(issue_func.br.cond),  // funct3 view
		.valid(br_valid), .cond(br_cond)
	);

	mlu #(.xlen(xlen)) mlu_i (
		.clock, .reset, .start(mul_start), .opa, .opb,
		.func(issue_func.alu), .valid(mul_valid), .result(mul_result)
	);

endmodule

/* verif/exec_stage_assertions.sv */
`timescale 1ns/100ps

// completion bus properties bound into fu_steer
module exec_stage_assertions (
	input logic clock,
	input logic reset,
	input logic alu_start,
	input logic br_start,
	input logic mul_start,
	input logic alu_valid,
	input logic br_valid,
	input logic mul_valid,
	input logic cdb_valid,
	input logic cdb_taken
);

	int fail_count = 0;  // read by the testbench

	// one unit result per cycle at most, which the or-merged cdb_valid relies on
	one_valid: assert property (@(posedge clock) disable iff (reset)
		$onehot0({alu_valid, br_valid, mul_valid}))
	else begin
		$error("more than one unit result in a cycle");
		fail_count++;
	end

	// fixed latency of one
	start_completes: assert property (@(posedge clock) disable iff (reset)
		(alu_start || br_start || mul_start) |=> cdb_valid)
	else begin
		$error("start not followed by cdb_valid");
		fail_count++;
	end

	// taken only ever comes back from a branch started one cycle before
	taken_from_branch: assert property (@(posedge clock) disable iff (reset)
		cdb_taken |-> $past(br_start))
	else begin
		$error("cdb_taken without a branch issue in the previous cycle");
		fail_count++;
	end

endmodule

bind fu_steer exec_stage_assertions steer_checks (
	.clock(clock), .reset(reset), .alu_start(alu_start), .br_start(br_start),
	.mul_start(mul_start), .alu_valid(alu_valid), .br_valid(br_valid),
	.mul_valid(mul_valid), .cdb_valid(cdb_valid), .cdb_taken(cdb_taken)
);

/* verif/exec_stage_tb.sv */
`timescale 1ns/100ps

// directed testbench for the integer execute stage
module exec_stage_tb;

	localparam int xlen         = 32;
	localparam int tag_width    = exec_pkg::tag_width;
	localparam int clock_period = 100;
	localparam int n_rand       = 4;                          // random pairs per function
	localparam int sweep_len    = 8 + n_rand;                 // corner pairs first
	localparam int sweep_cycles = 2 * sweep_len * (10 + 4 + 8);  // alu, mul, branch codes
	localparam int misc_cycles  = 12 + 14 + 32;               // reset, back to back, flush
	localparam int limit_cycles = sweep_cycles + misc_cycles + 200;

	logic                  clock;
	logic                  reset;
	logic                  issue_valid;
	exec_pkg::fu_unit_e    issue_unit;
	exec_pkg::exec_func_u  issue_func;
	logic [tag_width-1:0]  issue_tag;
	logic [xlen-1:0]       opa;
	logic [xlen-1:0]       opb;
	logic                  refresh;
	logic                  cdb_valid;
	logic [tag_width-1:0]  cdb_tag;
	logic [xlen-1:0]       cdb_value;
	logic                  cdb_taken;

	integer               seed = 32'h9be2;
	logic [tag_width-1:0] next_tag;  // bumps on every issue

	// equal, signed-less, unsigned-less, extremes, shift by 0 and 31
	logic [31:0] corner_a [8] = '{32'h00000000, 32'h80000000, 32'h00000001, 32'hffffffff,
		32'h7fffffff, 32'h12345678, 32'h87654321, 32'hfffffffd};
	logic [31:0] corner_b [8] = '{32'h00000000, 32'h00000001, 32'h80000000, 32'hffffffff,
		32'h7fffffff, 32'h00000000, 32'h0000001f, 32'h00000007};

	exec_stage #(.xlen(xlen), .tag_width(tag_width)) exec_stage_i (
		.clock, .reset, .issue_valid, .issue_unit, .issue_func, .issue_tag,
		.opa, .opb, .refresh, .cdb_valid, .cdb_tag, .cdb_value, .cdb_taken
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(limit_cycles * clock_period);
		$display("timeout: tests did not finish within %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	// first bound assertion failure ends the run
	initial begin
		wait (exec_stage_i.fu_steer_i.steer_checks.fail_count != 0);
		$display("assertion failure on the completion bus");
		$display("STATUS: FAIL");
		$fatal(1, "assertion failure");
	end

	// expected {taken, value}
	function automatic logic [32:0] predict(logic [1:0] unit, logic [3:0] func,
			logic [31:0] a, logic [31:0] b);
		longint          sa;
		longint          sb;
		longint unsigned ua;
		longint unsigned ub;
		logic [63:0]     prod_ss;
		logic [63:0]     prod_su;
		logic [63:0]     prod_uu;
		logic [4:0]      sh;
		logic            lt_s;
		logic            lt_u;
		logic            taken;
		logic [31:0]     value;
		sa      = $signed(a);  // sign extended to 64
		sb      = $signed(b);
		ua      = a;
		ub      = b;
		prod_ss = sa * sb;
		prod_su = sa * ub;
		prod_uu = ua * ub;
		sh      = b[4:0];
		lt_u    = a < b;
		lt_s    = (a ^ 32'h80000000) < (b ^ 32'h80000000);  // biased compare
		taken   = 1'b0;
		value   = exec_pkg::poison_value;
		case (unit)
			exec_pkg::unit_alu: begin
				case (func)
					exec_pkg::alu_add:  value = a + b;
					exec_pkg::alu_sub:  value = a - b;
					exec_pkg::alu_and:  value = a & b;
					exec_pkg::alu_or:   value = a | b;
					exec_pkg::alu_xor:  value = a ^ b;
					exec_pkg::alu_slt:  value = {31'b0, lt_s};
					exec_pkg::alu_sltu: value = {31'b0, lt_u};
					exec_pkg::alu_sll:  value = a << sh;
					exec_pkg::alu_srl:  value = a >> sh;
					exec_pkg::alu_sra:  value = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
					default: ;  // keeps poison
				endcase
			end
			exec_pkg::unit_mul: begin
				case (func)
					exec_pkg::alu_mul:    value = prod_ss[31:0];
					exec_pkg::alu_mulh:   value = prod_ss[63:32];
					exec_pkg::alu_mulhsu: value = prod_su[63:32];
					exec_pkg::alu_mulhu:  value = prod_uu[63:32];
					default: ;
				endcase
			end
			exec_pkg::unit_br: begin
				case (func[2:0])  // funct3 with the top bit ignored
					3'b000:  taken = a == b;
					3'b001:  taken = a != b;
					3'b100:  taken = lt_s;
					3'b101:  taken = !lt_s;
					3'b110:  taken = lt_u;
					3'b111:  taken = !lt_u;
					default: taken = 1'b0;
				endcase
				value = {31'b0, taken};
			end
			default: value = '0;  // unit code 3 never completes
		endcase
		return {taken, value};
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s at %0t: expected %h, got %h", name, $time, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic drive_issue(logic [1:0] unit, logic [3:0] func, logic [31:0] a,
			logic [31:0] b, logic [tag_width-1:0] tag, logic flush);
		@(posedge clock);
		issue_valid <= 1'b1;
		issue_unit  <= exec_pkg::fu_unit_e'(unit);
		issue_func  <= func;  // same bits feed both views
		issue_tag   <= tag;
		opa         <= a;
		opb         <= b;
		refresh     <= flush;
	endtask

	task automatic drive_idle();
		@(posedge clock);
		issue_valid <= 1'b0;
		refresh     <= 1'b0;
	endtask

	// sampled mid cycle once the bus settles
	task automatic expect_cdb(logic exp_valid, logic [tag_width-1:0] exp_tag,
			logic [32:0] exp_result);
		@(negedge clock);
		check_value("cdb_valid", exp_valid, cdb_valid);
		if (exp_valid) begin
			check_value("cdb_tag", exp_tag, cdb_tag);
			check_value("cdb_value", exp_result[31:0], cdb_value);
			check_value("cdb_taken", exp_result[32], cdb_taken);
		end else begin
			check_value("cdb_taken", 32'h0, cdb_taken);
		end
	endtask

	task automatic run_op(logic [1:0] unit, logic [3:0] func, logic [31:0] a, logic [31:0] b);
		logic [tag_width-1:0] tag;
		tag      = next_tag;
		next_tag = next_tag + 1'b1;
		drive_issue(unit, func, a, b, tag, 1'b0);
		drive_idle();
		expect_cdb(unit != exec_pkg::unit_inv, tag, predict(unit, func, a, b));
	endtask

	task automatic run_flushed(logic [1:0] unit, logic [3:0] func, logic [31:0] a,
			logic [31:0] b);
		drive_issue(unit, func, a, b, next_tag, 1'b1);
		drive_idle();
		expect_cdb(1'b0, '0, '0);  // dropped so nothing completes
	endtask

	task automatic sweep_operands(logic [1:0] unit, logic [3:0] func);
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < 8; i++) begin
			run_op(unit, func, corner_a[i], corner_b[i]);
		end
		for (int i = 0; i < n_rand; i++) begin
			a = $random(seed);
			b = $random(seed);
			run_op(unit, func, a, b);
		end
	endtask

	task automatic check_reset_state();
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			if (i == 0) begin
				issue_valid <= 1'b1;  // live beq on equal operands that reset must mask
				issue_unit  <= exec_pkg::unit_br;
			end
			if (i == 7) issue_valid <= 1'b0;
			if (i == 9) reset <= 1'b0;  // released after the 10th edge
			@(negedge clock);
			check_value("cdb_valid", 32'h0, cdb_valid);
			check_value("cdb_taken", 32'h0, cdb_taken);
			check_value("cdb_value", 32'h0, cdb_value);
		end
		@(negedge clock);  // first cycle out of reset
		check_value("cdb_valid", 32'h0, cdb_valid);
		check_value("cdb_taken", 32'h0, cdb_taken);
	endtask

	task automatic cover_alu_funcs();
		for (int f = exec_pkg::alu_add; f <= exec_pkg::alu_sra; f++) begin
			sweep_operands(exec_pkg::unit_alu, 4'(f));
		end
	endtask

	task automatic cover_mul_funcs();
		for (int f = exec_pkg::alu_mul; f <= exec_pkg::alu_mulhu; f++) begin
			sweep_operands(exec_pkg::unit_mul, 4'(f));
		end
	endtask

	task automatic cover_branch_conds();
		for (int f = 0; f < 8; f++) begin  // 010 and 011 included
			sweep_operands(exec_pkg::unit_br, 4'(f));
		end
	endtask

	task automatic stream_back_to_back();
		logic [1:0]           units [10] = '{exec_pkg::unit_alu, exec_pkg::unit_br,
			exec_pkg::unit_mul, exec_pkg::unit_alu, exec_pkg::unit_br, exec_pkg::unit_mul,
			exec_pkg::unit_alu, exec_pkg::unit_mul, exec_pkg::unit_br, exec_pkg::unit_alu};
		logic [3:0]           funcs [10] = '{exec_pkg::alu_add, 4'b0100, exec_pkg::alu_mulh,
			exec_pkg::alu_sra, 4'b0111, exec_pkg::alu_mulhu, exec_pkg::alu_xor,
			exec_pkg::alu_mul, 4'b0001, exec_pkg::alu_sub};
		logic [32:0]          exp_result [10];
		logic [tag_width-1:0] exp_tag [10];
		logic [31:0]          a;
		logic [31:0]          b;
		for (int i = 0; i < 10; i++) begin
			a             = $random(seed);
			b             = $random(seed);
			exp_tag[i]    = next_tag;
			next_tag      = next_tag + 1'b1;
			exp_result[i] = predict(units[i], funcs[i], a, b);
			drive_issue(units[i], funcs[i], a, b, exp_tag[i], 1'b0);
			if (i > 0) expect_cdb(1'b1, exp_tag[i-1], exp_result[i-1]);  // previous issue
		end
		drive_idle();
		expect_cdb(1'b1, exp_tag[9], exp_result[9]);
		drive_idle();
		expect_cdb(1'b0, '0, '0);  // no extra beat
	endtask

	task automatic flush_and_invalid();
		logic [32:0]          first;
		logic [32:0]          third;
		logic [tag_width-1:0] tag_a;
		logic [tag_width-1:0] tag_c;
		run_flushed(exec_pkg::unit_alu, exec_pkg::alu_add, 32'h11, 32'h22);
		run_flushed(exec_pkg::unit_br, 4'b0000, 32'h5, 32'h5);
		run_flushed(exec_pkg::unit_mul, exec_pkg::alu_mul, 32'h3, 32'h4);
		run_op(exec_pkg::unit_inv, exec_pkg::alu_add, 32'h1, 32'h2);
		run_op(exec_pkg::unit_alu, 4'd14, 32'h1, 32'h2);  // undefined code gives poison
		run_op(exec_pkg::unit_alu, 4'd15, 32'hdead, 32'hbeef);
		run_op(exec_pkg::unit_alu, exec_pkg::alu_mulh, 32'h7, 32'h9);
		run_op(exec_pkg::unit_mul, exec_pkg::alu_add, 32'h7, 32'h9);
		// registered op completes while the next one is flushed
		tag_a    = next_tag;
		tag_c    = tag_a + 2'd2;
		next_tag = next_tag + 2'd3;
		first    = predict(exec_pkg::unit_alu, exec_pkg::alu_sub, 32'h100, 32'h1);
		third    = predict(exec_pkg::unit_br, 4'b0001, 32'h1, 32'h2);
		drive_issue(exec_pkg::unit_alu, exec_pkg::alu_sub, 32'h100, 32'h1, tag_a, 1'b0);
		drive_issue(exec_pkg::unit_mul, exec_pkg::alu_mul, 32'h7, 32'h6, tag_a + 1'b1, 1'b1);
		expect_cdb(1'b1, tag_a, first);
		drive_issue(exec_pkg::unit_br, 4'b0001, 32'h1, 32'h2, tag_c, 1'b0);
		expect_cdb(1'b0, '0, '0);  // the flushed slot
		drive_idle();
		expect_cdb(1'b1, tag_c, third);
	endtask

	initial begin
		reset       <= 1'b1;
		issue_valid <= 1'b0;
		issue_unit  <= exec_pkg::unit_inv;
		issue_func  <= '0;
		issue_tag   <= '0;
		opa         <= '0;
		opb         <= '0;
		refresh     <= 1'b0;
		next_tag     = '0;
		check_reset_state();
		cover_alu_funcs();
		cover_mul_funcs();
		cover_branch_conds();
		stream_back_to_back();
		flush_and_invalid();
		repeat (2) @(posedge clock);  // last assertion attempts settle
		if (exec_stage_i.fu_steer_i.steer_checks.fail_count != 0) begin
			$display("%0d assertion failures on the completion bus",
				exec_stage_i.fu_steer_i.steer_checks.fail_count);
			$display("STATUS: FAIL");
			$fatal(1, "assertion failures");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* exec_stage.f */
verilog/exec_pkg.sv
verilog/alu.sv
verilog/brcond.sv
verilog/mlu.sv
verilog/fu_steer.sv
verilog/exec_stage.sv
verif/exec_stage_assertions.sv
verif/exec_stage_tb.sv

/* Bender.yml */
package:
  name: exec_stage

dependencies: {}

sources:
  - files:
      - verilog/exec_pkg.sv
      - verilog/alu.sv
      - verilog/brcond.sv
      - verilog/mlu.sv
      - verilog/fu_steer.sv
      - verilog/exec_stage.sv
  - target: simulation
    files:
      - verif/exec_stage_assertions.sv
      - verif/exec_stage_tb.sv
